/* build.f */
+incdir+source
source/pipe_front_pkg.sv
source/pipe_front_ifs.sv
source/icache_ctrl.sv
source/icache_line_store.sv
source/result_history.sv
source/operand_forward.sv
source/pipe_front.sv
testbench/pipe_front_assert.sv
testbench/pipe_front_tb.sv

/* testbench/pipe_front_tb.sv */
`default_nettype none

`include "pipe_front_cfg.svh"

module pipe_front_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// 173 fetches at up to 9 cycles and 300 forwarding cycles with margin
	localparam int CYCLE_LIMIT = 3000;

	logic clk, rst;
	logic fetch_req, instr_valid, mem_req, mem_valid, res_valid;
	logic [`ADDR_W-1:0] fetch_addr, mem_addr;
	logic [`INSTR_W-1:0] instr;
	logic [`LINE_W-1:0] mem_data;
	logic [`TAG_W-1:0] res_tag, rd_tag_a, rd_tag_b, rd_tag_c;
	logic [`DATA_W-1:0] res_data, file_data_a, file_data_b, file_data_c;
	logic [`DATA_W-1:0] opnd_a, opnd_b, opnd_c;

	integer seed;
	int cycle_count, check_count, error_count, test_errors, test_num;

	// Models of the cached line and the result history
	logic model_line_valid;
	logic [`BASE_W-1:0] model_line_base;
	logic hist_valid [`HIST_DEPTH];
	logic [`TAG_W-1:0] hist_tag [`HIST_DEPTH];
	logic [`DATA_W-1:0] hist_data [`HIST_DEPTH];

	logic [`ADDR_W-1:0] addr_a, addr_b;
	logic [`BASE_W-1:0] pool_base [3];
	logic [31:0] rnd;

	pipe_front pipe_front_i
	(
		.clk(clk), .rst(rst),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.instr_valid(instr_valid), .instr(instr),
		.mem_req(mem_req), .mem_addr(mem_addr),
		.mem_valid(mem_valid), .mem_data(mem_data),
		.res_valid(res_valid), .res_tag(res_tag), .res_data(res_data),
		.rd_tag_a(rd_tag_a), .rd_tag_b(rd_tag_b), .rd_tag_c(rd_tag_c),
		.file_data_a(file_data_a), .file_data_b(file_data_b), .file_data_c(file_data_c),
		.opnd_a(opnd_a), .opnd_b(opnd_b), .opnd_c(opnd_c)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("sim failed");
			$finish;
		end
	end

	// Memory contents mixed from the whole word address
	function automatic logic [`INSTR_W-1:0] word_model(input logic [`ADDR_W-1:0] addr);
		logic [31:0] mix;
		mix = addr * 32'h9e3779b1;
		return mix ^ {addr[15:0], addr[31:16]} ^ 32'h5a5ac3c3;
	endfunction

	function automatic logic [`LINE_W-1:0] line_model(input logic [`BASE_W-1:0] base);
		logic [`LINE_W-1:0] line;
		for (int k = 0; k < `LINE_WORDS; k++)
			line[k*`INSTR_W +: `INSTR_W] = word_model({base, 3'(k)});
		return line;
	endfunction

	function automatic logic [`DATA_W-1:0] expected_operand(input logic [`TAG_W-1:0] tag,
		input logic [`DATA_W-1:0] file_data);
		if (tag == '0)
			return '0;
		for (int i = 0; i < `HIST_DEPTH; i++)
			if (hist_valid[i] && hist_tag[i] == tag)
				return hist_data[i];
		return file_data;
	endfunction

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		check_count++;
		assert (got === exp)
		else
		begin
			error_count++;
			test_errors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic finish_test(input string name);
		test_num++;
		$display("Test %0d %s: %s, %0d errors", test_num, name,
			(test_errors == 0) ? "ok" : "errors", test_errors);
		test_errors = 0;
	endtask

	task automatic drive_operands();
		rd_tag_a <= $unsigned($random(seed)) % 16;
		rd_tag_b <= $unsigned($random(seed)) % 16;
		rd_tag_c <= $unsigned($random(seed)) % 16;
		file_data_a <= {$random(seed), $random(seed)};
		file_data_b <= {$random(seed), $random(seed)};
		file_data_c <= {$random(seed), $random(seed)};
	endtask

	task automatic check_operands();
		check_value("opnd_a", opnd_a, expected_operand(rd_tag_a, file_data_a));
		check_value("opnd_b", opnd_b, expected_operand(rd_tag_b, file_data_b));
		check_value("opnd_c", opnd_c, expected_operand(rd_tag_c, file_data_c));
	endtask

	task automatic run_fetch(input logic [`ADDR_W-1:0] addr);
		logic expect_hit;
		logic [31:0] noise;
		int delay;
		int waited;
		expect_hit = model_line_valid && (model_line_base == addr[`ADDR_W-1:`OFFSET_W]);
		@(posedge clk);
		fetch_req <= 1'b1;
		fetch_addr <= addr;
		@(posedge clk);
		fetch_req <= 1'b0;
		@(negedge clk);
		if (expect_hit)
		begin
			check_value("mem_req on hit", mem_req, 0);
			check_value("instr_valid on hit", instr_valid, 1);
		end
		else
		begin
			check_value("mem_req on miss", mem_req, 1);
			check_value("instr_valid on miss", instr_valid, 0);
			check_value("mem_addr", mem_addr, addr);
			// Memory answers after 1 to 4 cycles while stray fetches arrive
			delay = 1 + ($unsigned($random(seed)) % 4);
			for (int i = 0; i < delay; i++)
			begin
				@(posedge clk);
				noise = $random(seed);
				fetch_req <= noise[0];
				fetch_addr <= $random(seed);
			end
			mem_valid <= 1'b1;
			mem_data <= line_model(addr[`ADDR_W-1:`OFFSET_W]);
			@(posedge clk);
			mem_valid <= 1'b0;
			fetch_req <= 1'b0;
			waited = 0;
			@(negedge clk);
			while (!instr_valid && waited < 8)
			begin
				@(negedge clk);
				waited++;
			end
			check_count++;
			assert (instr_valid)
			else
			begin
				error_count++;
				test_errors++;
				$display("No instruction returned after the memory response at %0t ns", $time);
			end
			model_line_valid = 1'b1;
			model_line_base = addr[`ADDR_W-1:`OFFSET_W];
		end
		check_value("instr", instr, word_model(addr));
		@(negedge clk);
		check_value("instr_valid after one cycle", instr_valid, 0);
	endtask

	initial
	begin
		seed = 22;
		clk = 1'b0;
		rst = 1'b1;
		fetch_req = 1'b0;
		fetch_addr = '0;
		mem_valid = 1'b0;
		mem_data = '0;
		res_valid = 1'b0;
		res_tag = '0;
		res_data = '0;
		rd_tag_a = '0;
		rd_tag_b = '0;
		rd_tag_c = '0;
		file_data_a = '0;
		file_data_b = '0;
		file_data_c = '0;
		model_line_valid = 1'b0;
		model_line_base = '0;
		for (int i = 0; i < `HIST_DEPTH; i++)
			hist_valid[i] = 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		repeat (6)
		begin
			@(posedge clk);
			drive_operands();
			@(negedge clk);
			check_value("instr_valid while idle", instr_valid, 0);
			check_value("mem_req while idle", mem_req, 0);
			check_operands();
		end
		finish_test("reset and idle");

		addr_a = $random(seed);
		run_fetch(addr_a);
		finish_test("first fetch miss");

		repeat (20)
		begin
			rnd = $random(seed);
			run_fetch({addr_a[`ADDR_W-1:`OFFSET_W], rnd[`OFFSET_W-1:0]});
		end
		finish_test("same line hits");

		addr_b = $random(seed);
		if (addr_b[`ADDR_W-1:`OFFSET_W] == addr_a[`ADDR_W-1:`OFFSET_W])
			addr_b[`OFFSET_W] = ~addr_b[`OFFSET_W];
		run_fetch(addr_b);
		rnd = $random(seed);
		run_fetch({addr_a[`ADDR_W-1:`OFFSET_W], rnd[`OFFSET_W-1:0]});
		// Small pool of lines so hits and misses mix
		pool_base[0] = addr_a[`ADDR_W-1:`OFFSET_W];
		pool_base[1] = addr_b[`ADDR_W-1:`OFFSET_W];
		rnd = $random(seed);
		pool_base[2] = rnd[`BASE_W-1:0];
		repeat (150)
		begin
			rnd = $random(seed);
			run_fetch({pool_base[$unsigned(rnd[31:8]) % 3], rnd[`OFFSET_W-1:0]});
		end
		finish_test("line replacement");

		repeat (300)
		begin
			@(posedge clk);
			// Result driven last cycle enters the history at this edge
			if (res_valid)
			begin
				for (int i = `HIST_DEPTH - 1; i > 0; i--)
				begin
					hist_valid[i] = hist_valid[i-1];
					hist_tag[i] = hist_tag[i-1];
					hist_data[i] = hist_data[i-1];
				end
				hist_valid[0] = 1'b1;
				hist_tag[0] = res_tag;
				hist_data[0] = res_data;
			end
			rnd = $random(seed);
			res_valid <= rnd[0] | rnd[1];
			res_tag <= rnd[7:4];
			res_data <= {$random(seed), $random(seed)};
			drive_operands();
			@(negedge clk);
			check_operands();
		end
		finish_test("operand forwarding");

		error_count += pipe_front_i.icache_ctrl_i.pipe_front_assert_i.fail_count;
		$display("Summary: %0d tests, %0d checks, %0d errors", test_num, check_count,
			error_count);
		if (error_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/pipe_front_assert.sv */
`default_nettype none

module pipe_front_assert
(
	input logic clk,
	input logic rst,
	input logic mem_req,
	input logic instr_valid,
	input pipe_front_pkg::icache_state_t state
);

	timeunit 1ns;
	timeprecision 1ps;

	import pipe_front_pkg::*;

	int fail_count = 0;

	property p_mem_req_single;
		@(posedge clk) disable iff (rst)
		mem_req |=> !mem_req;
	endproperty

	property p_req_valid_exclusive;
		@(posedge clk) disable iff (rst)
		!(mem_req && instr_valid);
	endproperty

	// No second request while a refill is outstanding
	property p_no_req_while_waiting;
		@(posedge clk) disable iff (rst)
		(state == ST_WAIT_MEM) |=> !mem_req;
	endproperty

	a_mem_req_single: assert property (p_mem_req_single)
	else
	begin
		fail_count++;
		$error("mem_req high for more than one cycle");
	end

	a_req_valid_exclusive: assert property (p_req_valid_exclusive)
	else
	begin
		fail_count++;
		$error("mem_req and instr_valid high together");
	end

	a_no_req_while_waiting: assert property (p_no_req_while_waiting)
	else
	begin
		fail_count++;
		$error("mem_req issued while waiting for memory");
	end

endmodule

bind icache_ctrl pipe_front_assert pipe_front_assert_i
(
	.clk(clk),
	.rst(rst),
	.mem_req(mem_req),
	.instr_valid(instr_valid),
	.state(state)
);

`default_nettype wire

/* source/pipe_front.sv */
`default_nettype none

`include "pipe_front_cfg.svh"

module pipe_front
(
	input logic clk,
	input logic rst,

	// Instruction fetch
	input logic fetch_req,
	input logic [`ADDR_W-1:0] fetch_addr,
	output logic instr_valid,
	output logic [`INSTR_W-1:0] instr,

	// Line refill from memory
	output logic mem_req,
	output logic [`ADDR_W-1:0] mem_addr,
	input logic mem_valid,
	input logic [`LINE_W-1:0] mem_data,

	// Results leaving execute
	input logic res_valid,
	input logic [`TAG_W-1:0] res_tag,
	input logic [`DATA_W-1:0] res_data,

	// Operand reads
	input logic [`TAG_W-1:0] rd_tag_a,
	input logic [`TAG_W-1:0] rd_tag_b,
	input logic [`TAG_W-1:0] rd_tag_c,
	input logic [`DATA_W-1:0] file_data_a,
	input logic [`DATA_W-1:0] file_data_b,
	input logic [`DATA_W-1:0] file_data_c,
	output logic [`DATA_W-1:0] opnd_a,
	output logic [`DATA_W-1:0] opnd_b,
	output logic [`DATA_W-1:0] opnd_c
);

	icache_line_if line_bus();
	fwd_history_if hist_bus();

	icache_ctrl icache_ctrl_i
	(
		.clk(clk),
		.rst(rst),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.instr_valid(instr_valid),
		.instr(instr),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_valid(mem_valid),
		.mem_data(mem_data),
		.line_bus(line_bus.ctrl)
	);

	icache_line_store icache_line_store_i
	(
		.clk(clk),
		.rst(rst),
		.line_bus(line_bus.store)
	);

	result_history result_history_i
	(
		.clk(clk),
		.rst(rst),
		.res_valid(res_valid),
		.res_tag(res_tag),
		.res_data(res_data),
		.hist(hist_bus.source)
	);

	// One selector per operand port, all reading the same history
	operand_forward fwd_a_i
	(
		.hist(hist_bus.sink),
		.rd_tag(rd_tag_a),
		.file_data(file_data_a),
		.opnd(opnd_a)
	);

	operand_forward fwd_b_i
	(
		.hist(hist_bus.sink),
		.rd_tag(rd_tag_b),
		.file_data(file_data_b),
		.opnd(opnd_b)
	);

	operand_forward fwd_c_i
	(
		.hist(hist_bus.sink),
		.rd_tag(rd_tag_c),
		.file_data(file_data_c),
		.opnd(opnd_c)
	);

endmodule

`default_nettype wire

/* source/operand_forward.sv */
`default_nettype none

`include "pipe_front_cfg.svh"

module operand_forward
(
	fwd_history_if.sink hist,

	input logic [`TAG_W-1:0] rd_tag,
	input logic [`DATA_W-1:0] file_data,
	output logic [`DATA_W-1:0] opnd
);

	import pipe_front_pkg::*;

	logic [`HIST_DEPTH-1:0] match;
	fwd_src_t src;

	for (genvar i = 0; i < `HIST_DEPTH; i++)
	begin : g_match
		assign match[i] = hist.entries[i].valid && (hist.entries[i].tag == rd_tag);
	end

	// Youngest match wins, tag 0 never forwards
	always_comb
	begin
		src = FWD_ZERO;
		if (rd_tag != '0)
		begin
			if (match[0])
				src = FWD_EXEC;
			else if (match[1])
				src = FWD_WB;
			else if (match[2])
				src = FWD_WB_PAST;
			else
				src = FWD_FILE;
		end
	end

	always_comb
	begin
		case (src)
			FWD_EXEC:
				opnd = hist.entries[0].data;
			FWD_WB:
				opnd = hist.entries[1].data;
			FWD_WB_PAST:
				opnd = hist.entries[2].data;
			FWD_FILE:
				opnd = file_data;
			default:
				opnd = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/result_history.sv */
`default_nettype none

`include "pipe_front_cfg.svh"

module result_history
(
	input logic clk,
	input logic rst,

	input logic res_valid,
	input logic [`TAG_W-1:0] res_tag,
	input logic [`DATA_W-1:0] res_data,

	fwd_history_if.source hist
);

	import pipe_front_pkg::*;

	fwd_entry_t hist_q [`HIST_DEPTH];

	// Youngest result in slot 0, older ones move down
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `HIST_DEPTH; i++)
				hist_q[i].valid <= 1'b0;
		end
		else if (res_valid)
		begin
			hist_q[0] <= '{valid: 1'b1, tag: res_tag, data: res_data};
			for (int i = 1; i < `HIST_DEPTH; i++)
				hist_q[i] <= hist_q[i-1];
		end
	end

	assign hist.entries = hist_q;

endmodule

`default_nettype wire

/* source/icache_line_store.sv */
`default_nettype none

`include "pipe_front_cfg.svh"

module icache_line_store
(
	input logic clk,
	input logic rst,

	icache_line_if.store line_bus
);

	logic line_init;
	logic [`BASE_W-1:0] line_base;
	logic [`LINE_W-1:0] line_data;

	logic [`LINE_WORDS-1:0][`INSTR_W-1:0] src_words;

	// Nothing is held until the first refill
	always_ff @(posedge clk)
	begin
		if (rst)
			line_init <= 1'b0;
		else if (line_bus.fill)
			line_init <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (line_bus.fill)
		begin
			line_base <= line_bus.fill_base;
			line_data <= line_bus.fill_data;
		end
	end

	assign line_bus.hit = line_init && (line_base == line_bus.lookup_base);

	// Refill data bypasses the stored line
	assign src_words = line_bus.word_from_fill ? line_bus.fill_data : line_data;
	assign line_bus.word = src_words[line_bus.word_offset];

endmodule

`default_nettype wire

/* source/icache_ctrl.sv */
`default_nettype none

`include "pipe_front_cfg.svh"

module icache_ctrl
(
	input logic clk,
	input logic rst,

	input logic fetch_req,
	input logic [`ADDR_W-1:0] fetch_addr,
	output logic instr_valid,
	output logic [`INSTR_W-1:0] instr,

	output logic mem_req,
	output logic [`ADDR_W-1:0] mem_addr,
	input logic mem_valid,
	input logic [`LINE_W-1:0] mem_data,

	icache_line_if.ctrl line_bus
);

	import pipe_front_pkg::*;

	icache_state_t state;

	logic accept;
	logic waiting;
	logic fill;
	logic [`BASE_W-1:0] miss_base;
	logic [`OFFSET_W-1:0] miss_offset;

	// Requests are only taken while no refill is outstanding
	assign accept = (state == ST_IDLE) && fetch_req;
	assign waiting = (state == ST_WAIT_MEM);
	assign fill = waiting && mem_valid;

	// mem_addr keeps the missed request until the line comes back
	assign miss_base = mem_addr[`ADDR_W-1:`OFFSET_W];
	assign miss_offset = mem_addr[`OFFSET_W-1:0];

	assign line_bus.lookup_base = fetch_addr[`ADDR_W-1:`OFFSET_W];
	assign line_bus.fill = fill;
	assign line_bus.fill_base = miss_base;
	assign line_bus.fill_data = mem_data;
	assign line_bus.word_from_fill = waiting;
	assign line_bus.word_offset = waiting ? miss_offset : fetch_addr[`OFFSET_W-1:0];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			mem_req <= 1'b0;
			instr_valid <= 1'b0;
		end
		else
		begin
			mem_req <= 1'b0;
			instr_valid <= 1'b0;

			case (state)
				ST_IDLE:
				begin
					if (fetch_req)
					begin
						if (line_bus.hit)
						begin
							instr_valid <= 1'b1;
						end
						else
						begin
							mem_req <= 1'b1;
							state <= ST_WAIT_MEM;
						end
					end
				end

				ST_WAIT_MEM:
				begin
					// Fetch requests are dropped here
					if (mem_valid)
					begin
						instr_valid <= 1'b1;
						state <= ST_IDLE;
					end
				end

				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Instruction word and refill address
	always_ff @(posedge clk)
	begin
		if (accept && line_bus.hit)
			instr <= line_bus.word;
		else if (accept)
			mem_addr <= fetch_addr;
		else if (fill)
			instr <= line_bus.word;
	end

endmodule

`default_nettype wire

/* source/pipe_front_ifs.sv */
`default_nettype none

`include "pipe_front_cfg.svh"

// Between the cache controller and the line storage
interface icache_line_if;

	logic fill;
	logic [`BASE_W-1:0] fill_base;
	logic [`LINE_W-1:0] fill_data;
	logic [`BASE_W-1:0] lookup_base;
	logic hit;
	logic [`OFFSET_W-1:0] word_offset;
	logic word_from_fill;
	logic [`INSTR_W-1:0] word;

	modport ctrl
	(
		output fill, fill_base, fill_data, lookup_base, word_offset, word_from_fill,
		input hit, word
	);

	modport store
	(
		input fill, fill_base, fill_data, lookup_base, word_offset, word_from_fill,
		output hit, word
	);

endinterface

// Recent results, index 0 is the youngest
interface fwd_history_if;

	import pipe_front_pkg::*;

	fwd_entry_t entries [`HIST_DEPTH];

	modport source
	(
		output entries
	);

	modport sink
	(
		input entries
	);

endinterface

`default_nettype wire

/* source/pipe_front_pkg.sv */
`default_nettype none

`include "pipe_front_cfg.svh"

package pipe_front_pkg;

	// Single-line cache controller states
	typedef enum logic
	{
		ST_IDLE,
		ST_WAIT_MEM
	} icache_state_t;

	// One slot of the recent result history
	typedef struct packed
	{
		logic valid;
		logic [`TAG_W-1:0] tag;
		logic [`DATA_W-1:0] data;
	} fwd_entry_t;

	// Where an operand port takes its data from, highest priority first
	typedef enum logic [2:0]
	{
		FWD_EXEC,
		FWD_WB,
		FWD_WB_PAST,
		FWD_FILE,
		FWD_ZERO
	} fwd_src_t;

endpackage

`default_nettype wire

/* source/pipe_front_cfg.svh */
`ifndef PIPE_FRONT_CFG_SVH
`define PIPE_FRONT_CFG_SVH

// Fetch side
`define ADDR_W 32
`define INSTR_W 32
`define LINE_WORDS 8
`define LINE_W 256

// Split of a fetch address into line base and word offset
`define OFFSET_W 3
`define BASE_W 29

// Forwarding side
`define TAG_W 4
`define DATA_W 64

// Execute, write-back, write-back-past
`define HIST_DEPTH 3

`endif
